/* flist.f */
source/game_types_pkg.sv
source/control_cfg_pkg.sv
source/uart_command_rx.sv
source/debouncer.sv
source/panel_command_source.sv
source/gravity_timer.sv
source/command_arbiter.sv
source/command_queue.sv
source/game_control.sv
verification/game_control_sva.sv
verification/game_control_tb.sv

/* source/command_arbiter.sv */
module command_arbiter (
  input  logic                     uart_cmd_valid,
  input  game_types_pkg::command_t uart_cmd,
  input  logic [3:0]               btn_press,
  input  logic [3:0]               sw_press,
  input  logic                     gravity_req,
  output game_types_pkg::command_t granted_cmd
);
  import game_types_pkg::*;

  // Fixed priority, losing pulses are dropped.
  always_comb begin
    if (uart_cmd_valid)
      granted_cmd = uart_cmd;
    else if (btn_press[0])
      granted_cmd = RIGHT;
    else if (btn_press[1])
      granted_cmd = DOWN;
    else if (btn_press[2])
      granted_cmd = LEFT;
    else if (btn_press[3])
      granted_cmd = HOLD;
    else if (sw_press[0])
      granted_cmd = DROP;
    else if (sw_press[1])
      granted_cmd = ROTATE;
    else if (sw_press[2])
      granted_cmd = ROTATE_REV;
    else if (sw_press[3])
      granted_cmd = BAR;
    else if (gravity_req)
      granted_cmd = DOWN;
    else
      granted_cmd = NONE;
  end

endmodule

/* source/command_queue.sv */
module command_queue (
  input  logic                        clk,
  input  logic                        reset_n,
  input  game_types_pkg::game_state_t state,
  input  game_types_pkg::command_t    granted_cmd,
  output game_types_pkg::command_t    control
);
  import game_types_pkg::*;
  import control_cfg_pkg::*;

  localparam int unsigned CW = $clog2(QUEUE_DEPTH + 1);
  localparam logic [CW-1:0] FULL = CW'(QUEUE_DEPTH);

  command_t      entries [QUEUE_DEPTH];
  logic [CW-1:0] occupancy;
  logic [CW-1:0] wr_idx;
  logic          pop;
  logic          push;

  // The engine takes the head on every WAIT cycle.
  assign pop = (state == WAIT) && (occupancy != '0);

  // A pop in the same cycle frees a slot for the new entry.
  assign push = (granted_cmd != NONE) && (pop || (occupancy != FULL));

  assign wr_idx = pop ? occupancy - 1'b1 : occupancy;

  // ####################
  // Occupancy.
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      occupancy <= '0;
    end else begin
      case ({push, pop})
        2'b10:   occupancy <= occupancy + 1'b1;
        2'b01:   occupancy <= occupancy - 1'b1;
        default: occupancy <= occupancy;
      endcase
    end
  end

  // ####################
  // Shifting storage.
  always_ff @(posedge clk) begin
    for (int i = 0; i < QUEUE_DEPTH; i++) begin
      if (push && (CW'(i) == wr_idx))
        entries[i] <= granted_cmd;
      else if (pop && (i < QUEUE_DEPTH - 1))
        entries[i] <= entries[i+1];
    end
  end

  // Storage is not cleared, so an empty queue masks the head.
  assign control = (occupancy == '0) ? NONE : entries[0];

endmodule

/* source/control_cfg_pkg.sv */
package control_cfg_pkg;

  // Command queue entries.
  localparam int unsigned QUEUE_DEPTH = 16;

  // Gravity period in clock cycles.
  localparam int unsigned GRAVITY_TICK = 50_000_000;

  // UART bit time in clock cycles.
  localparam int unsigned UART_CLOCKS_PER_BIT = 434;

  // Stable time a mechanical input needs before it is accepted.
  localparam int unsigned DEBOUNCE_CYCLES = 1_000_000;

endpackage

/* source/debouncer.sv */
module debouncer #(
  parameter int unsigned stable_cycles = control_cfg_pkg::DEBOUNCE_CYCLES
) (
  input  logic clk,
  input  logic reset_n,
  input  logic in,
  output logic out
);

  localparam int unsigned CW = $clog2(stable_cycles + 1);
  localparam logic [CW-1:0] LAST_COUNT = CW'(stable_cycles - 1);

  logic          in_meta;
  logic          in_sync;
  logic [CW-1:0] count;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      in_meta <= 1'b0;
      in_sync <= 1'b0;
      out     <= 1'b0;
      count   <= '0;
    end else begin
      in_meta <= in;
      in_sync <= in_meta;
      // Any return to the current level restarts the wait.
      if (in_sync == out) begin
        count <= '0;
      end else if (count == LAST_COUNT) begin
        out   <= in_sync;
        count <= '0;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

endmodule

/* source/game_control.sv */
module game_control #(
  parameter int unsigned gravity_tick    = control_cfg_pkg::GRAVITY_TICK,
  parameter int unsigned clocks_per_bit  = control_cfg_pkg::UART_CLOCKS_PER_BIT,
  parameter int unsigned debounce_cycles = control_cfg_pkg::DEBOUNCE_CYCLES
) (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        uart_rx,
  input  logic [3:0]                  usr_btn,
  input  logic [3:0]                  usr_sw,
  input  game_types_pkg::game_state_t state,
  output game_types_pkg::command_t    control
);
  import game_types_pkg::*;

  logic       uart_cmd_valid;
  command_t   uart_cmd;
  logic [3:0] btn_press;
  logic [3:0] sw_press;
  logic       gravity_req;
  command_t   granted_cmd;

  // ####################
  // Command sources.
  uart_command_rx #(
    .clocks_per_bit(clocks_per_bit)
  ) i_uart_command_rx (
    .clk           (clk),
    .reset_n       (reset_n),
    .rx            (uart_rx),
    .uart_cmd_valid(uart_cmd_valid),
    .uart_cmd      (uart_cmd)
  );

  panel_command_source #(
    .stable_cycles(debounce_cycles)
  ) i_panel_command_source (
    .clk      (clk),
    .reset_n  (reset_n),
    .usr_btn  (usr_btn),
    .usr_sw   (usr_sw),
    .btn_press(btn_press),
    .sw_press (sw_press)
  );

  gravity_timer #(
    .tick_period(gravity_tick)
  ) i_gravity_timer (
    .clk        (clk),
    .reset_n    (reset_n),
    .state      (state),
    .granted_cmd(granted_cmd),
    .gravity_req(gravity_req)
  );

  // ####################
  // Arbitration and queue.
  command_arbiter i_command_arbiter (
    .uart_cmd_valid(uart_cmd_valid),
    .uart_cmd      (uart_cmd),
    .btn_press     (btn_press),
    .sw_press      (sw_press),
    .gravity_req   (gravity_req),
    .granted_cmd   (granted_cmd)
  );

  command_queue i_command_queue (
    .clk        (clk),
    .reset_n    (reset_n),
    .state      (state),
    .granted_cmd(granted_cmd),
    .control    (control)
  );

endmodule

/* source/game_types_pkg.sv */
package game_types_pkg;

  // Engine state as seen by the input subsystem.
  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    ACT
  } game_state_t;

  // Player commands, NONE marks an empty slot or no request.
  typedef enum logic [3:0] {
    NONE,
    LEFT,
    RIGHT,
    DOWN,
    DROP,
    HOLD,
    ROTATE,
    ROTATE_REV,
    BAR
  } command_t;

endpackage

/* source/gravity_timer.sv */
module gravity_timer #(
  parameter int unsigned tick_period = control_cfg_pkg::GRAVITY_TICK
) (
  input  logic                        clk,
  input  logic                        reset_n,
  input  game_types_pkg::game_state_t state,
  input  game_types_pkg::command_t    granted_cmd,
  output logic                        gravity_req
);
  import game_types_pkg::*;

  localparam int unsigned CW = $clog2(tick_period + 1);
  localparam logic [CW-1:0] TICK = CW'(tick_period);

  logic [CW-1:0] count;

  always_ff @(posedge clk) begin
    if (!reset_n)
      count <= '0;
    else if (granted_cmd == DOWN)
      count <= '0;
    else if (state != IDLE)
      // Restart also when the request lost arbitration.
      count <= (count == TICK) ? '0 : count + 1'b1;
  end

  assign gravity_req = (state != IDLE) && (count == TICK);

endmodule

/* source/panel_command_source.sv */
module panel_command_source #(
  parameter int unsigned stable_cycles = control_cfg_pkg::DEBOUNCE_CYCLES
) (
  input  logic       clk,
  input  logic       reset_n,
  input  logic [3:0] usr_btn,
  input  logic [3:0] usr_sw,
  output logic [3:0] btn_press,
  output logic [3:0] sw_press
);

  logic [7:0] raw_level;
  logic [7:0] clean_level;
  logic [7:0] prev_level;
  logic [7:0] press;

  // Buttons in the low half, switches in the high half.
  assign raw_level = {usr_sw, usr_btn};

  for (genvar gi = 0; gi < 8; gi++) begin : g_filter
    debouncer #(
      .stable_cycles(stable_cycles)
    ) i_debouncer (
      .clk    (clk),
      .reset_n(reset_n),
      .in     (raw_level[gi]),
      .out    (clean_level[gi])
    );
  end

  always_ff @(posedge clk) begin
    if (!reset_n)
      prev_level <= '0;
    else
      prev_level <= clean_level;
  end

  // One pulse per new press, a held input stays quiet.
  assign press = clean_level & ~prev_level;

  assign btn_press = press[3:0];
  assign sw_press  = press[7:4];

endmodule

/* source/uart_command_rx.sv */
module uart_command_rx #(
  parameter int unsigned clocks_per_bit = control_cfg_pkg::UART_CLOCKS_PER_BIT
) (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic                    rx,
  output logic                    uart_cmd_valid,
  output game_types_pkg::command_t uart_cmd
);
  import game_types_pkg::*;

  localparam int unsigned CW = $clog2(clocks_per_bit + 1);
  localparam logic [CW-1:0] LAST_TICK = CW'(clocks_per_bit - 1);
  localparam logic [CW-1:0] HALF_TICK = CW'(clocks_per_bit / 2 - 1);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  rx_state_t       rx_state;
  logic            rx_meta;
  logic            rx_sync;
  logic [CW-1:0]   clk_count;
  logic [2:0]      bit_index;
  logic [7:0]      rx_byte;
  logic            data_sample;
  logic            stop_sample;
  command_t        decoded_cmd;

  // Line idles high.
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  assign data_sample = (rx_state == RX_DATA) && (clk_count == LAST_TICK);
  assign stop_sample = (rx_state == RX_STOP) && (clk_count == LAST_TICK);

  // ####################
  // Frame FSM.
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      rx_state       <= RX_IDLE;
      clk_count      <= '0;
      bit_index      <= '0;
      uart_cmd_valid <= 1'b0;
    end else begin
      uart_cmd_valid <= 1'b0;
      case (rx_state)
        RX_IDLE: begin
          clk_count <= '0;
          if (!rx_sync)
            rx_state <= RX_START;
        end
        RX_START: begin
          if (clk_count == HALF_TICK) begin
            clk_count <= '0;
            bit_index <= '0;
            // A glitch shorter than half a bit is not a start bit.
            rx_state  <= rx_sync ? RX_IDLE : RX_DATA;
          end else begin
            clk_count <= clk_count + 1'b1;
          end
        end
        RX_DATA: begin
          if (data_sample) begin
            clk_count <= '0;
            bit_index <= bit_index + 1'b1;
            if (bit_index == 3'd7)
              rx_state <= RX_STOP;
          end else begin
            clk_count <= clk_count + 1'b1;
          end
        end
        default: begin
          if (stop_sample) begin
            clk_count      <= '0;
            rx_state       <= RX_IDLE;
            uart_cmd_valid <= rx_sync && (decoded_cmd != NONE);
          end else begin
            clk_count <= clk_count + 1'b1;
          end
        end
      endcase
    end
  end

  // LSB first.
  always_ff @(posedge clk) begin
    if (data_sample)
      rx_byte <= {rx_sync, rx_byte[7:1]};
  end

  // ####################
  // Key map.
  always_comb begin
    case (rx_byte)
      "A", "a":      decoded_cmd = LEFT;
      "D", "d":      decoded_cmd = RIGHT;
      "S", "s":      decoded_cmd = DOWN;
      "W", "w", " ": decoded_cmd = DROP;
      "C", "c":      decoded_cmd = HOLD;
      "X", "x":      decoded_cmd = ROTATE;
      "Z", "z":      decoded_cmd = ROTATE_REV;
      "B", "b":      decoded_cmd = BAR;
      default:       decoded_cmd = NONE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (stop_sample)
      uart_cmd <= decoded_cmd;
  end

endmodule

/* verification/game_control_sva.sv */
module game_control_sva (
  input logic                                                clk,
  input logic                                                reset_n,
  input logic [$clog2(control_cfg_pkg::QUEUE_DEPTH + 1)-1:0] occupancy,
  input game_types_pkg::command_t                            control,
  input logic                                                uart_cmd_valid,
  input logic [3:0]                                          btn_press,
  input logic [3:0]                                          sw_press,
  input logic                                                gravity_req,
  input game_types_pkg::command_t                            granted_cmd
);
  import game_types_pkg::*;
  import control_cfg_pkg::*;

  logic any_request;

  assign any_request = uart_cmd_valid || (btn_press != '0) || (sw_press != '0) || gravity_req;

  occupancy_in_range: assert property (@(posedge clk) disable iff (!reset_n)
    occupancy <= QUEUE_DEPTH)
    else $error("Queue occupancy above its depth.");

  // An empty queue with no grant stays empty and shows no command.
  empty_head_none: assert property (@(posedge clk) disable iff (!reset_n)
    ((occupancy == '0) && (granted_cmd == NONE)) |=> (control == NONE))
    else $error("Empty queue drives a command at its head.");

  grant_matches_request: assert property (@(posedge clk) disable iff (!reset_n)
    (granted_cmd == NONE) == !any_request)
    else $error("Arbiter grant does not match the requests.");

endmodule

bind game_control game_control_sva i_game_control_sva (
  .clk           (clk),
  .reset_n       (reset_n),
  .occupancy     (i_command_queue.occupancy),
  .control       (control),
  .uart_cmd_valid(uart_cmd_valid),
  .btn_press     (btn_press),
  .sw_press      (sw_press),
  .gravity_req   (gravity_req),
  .granted_cmd   (granted_cmd)
);

/* verification/game_control_tb.sv */
module game_control_tb;
  import game_types_pkg::*;
  import control_cfg_pkg::*;

  localparam int SIM_GRAVITY_TICK = 400;
  localparam int SIM_BIT_CYCLES   = 8;
  localparam int SIM_DEBOUNCE     = 6;
  localparam int RESET_CYCLES     = 8;
  localparam int PRESS_CYCLES     = SIM_DEBOUNCE + 4;
  localparam int RELEASE_CYCLES   = SIM_DEBOUNCE + 6;
  localparam int LONG_HOLD        = 60;
  localparam int BTN_TRIALS       = 8;
  localparam int SW_TRIALS        = 2;
  localparam int DRAIN_LIMIT      = 2 * QUEUE_DEPTH;
  localparam int QUIET_CYCLES     = 8;
  localparam int DRAIN_LEN        = DRAIN_LIMIT + QUIET_CYCLES + 2;
  localparam string KEY_CHARS     = "AaDdSsWw CcXxZzBb";

  // Planned length of each test in cycles.
  localparam int T6_LEN = 40 + PRESS_CYCLES + RELEASE_CYCLES + DRAIN_LEN;
  localparam int T1_LEN = 34 * 12 * SIM_BIT_CYCLES + 5 * DRAIN_LEN;
  localparam int T2_LEN = BTN_TRIALS * (4 + PRESS_CYCLES + 7 + 2 * RELEASE_CYCLES) + DRAIN_LEN;
  localparam int T3_LEN = SW_TRIALS * (LONG_HOLD + 2 * RELEASE_CYCLES + PRESS_CYCLES
                                       + 2 * DRAIN_LEN);
  localparam int T4_LEN = (QUEUE_DEPTH + 2) * (PRESS_CYCLES + RELEASE_CYCLES) + DRAIN_LEN;
  localparam int T5_LEN = 2 * (3 * SIM_GRAVITY_TICK + 20);
  localparam int TIMEOUT_CYCLES = 2 * (6 * (RESET_CYCLES + 1) + T6_LEN + T1_LEN + T2_LEN
                                       + T3_LEN + T4_LEN + T5_LEN);

  logic        clk;
  logic        reset_n;
  logic        uart_rx;
  logic [3:0]  usr_btn;
  logic [3:0]  usr_sw;
  game_state_t state;
  command_t    control;

  logic [15:0] lfsr;
  command_t    model_queue [$];
  int          cycle_count = 0;

  game_control #(
    .gravity_tick   (SIM_GRAVITY_TICK),
    .clocks_per_bit (SIM_BIT_CYCLES),
    .debounce_cycles(SIM_DEBOUNCE)
  ) i_game_control (
    .clk    (clk),
    .reset_n(reset_n),
    .uart_rx(uart_rx),
    .usr_btn(usr_btn),
    .usr_sw (usr_sw),
    .state  (state),
    .control(control)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
      report_failure("Timeout, the tests did not finish within the cycle limit.");
  end

  // ####################
  // Helpers.
  task automatic report_failure(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [31:0] actual,
                             input logic [31:0] expected_value);
    if (actual !== expected_value) begin
      report_failure($sformatf("Error: %s is %h, expected %h", name, actual, expected_value));
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit.
  function automatic logic [7:0] rand_bits(input int count);
    logic [7:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr  = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      value = {value[6:0], lfsr[0]};
    end
    return value;
  endfunction

  task automatic wait_cycles(input int count);
    repeat (count) @(posedge clk);
    #5;
  endtask

  function automatic command_t key_command(input logic [7:0] key);
    command_t cmd;
    case (key)
      "A", "a":      cmd = LEFT;
      "D", "d":      cmd = RIGHT;
      "S", "s":      cmd = DOWN;
      "W", "w", " ": cmd = DROP;
      "C", "c":      cmd = HOLD;
      "X", "x":      cmd = ROTATE;
      "Z", "z":      cmd = ROTATE_REV;
      "B", "b":      cmd = BAR;
      default:       cmd = NONE;
    endcase
    return cmd;
  endfunction

  function automatic command_t panel_command(input logic is_switch, input logic [1:0] idx);
    command_t cmd;
    case ({is_switch, idx})
      3'd0:    cmd = RIGHT;
      3'd1:    cmd = DOWN;
      3'd2:    cmd = LEFT;
      3'd3:    cmd = HOLD;
      3'd4:    cmd = DROP;
      3'd5:    cmd = ROTATE;
      3'd6:    cmd = ROTATE_REV;
      default: cmd = BAR;
    endcase
    return cmd;
  endfunction

  // The queue keeps the first QUEUE_DEPTH commands while nothing drains it.
  task automatic push_expected(input command_t cmd);
    if ((cmd != NONE) && (model_queue.size() < QUEUE_DEPTH))
      model_queue.push_back(cmd);
  endtask

  task automatic apply_reset();
    reset_n = 1'b0;
    state   = IDLE;
    model_queue.delete();
    wait_cycles(RESET_CYCLES);
    reset_n = 1'b1;
    @(negedge clk);
    check_equal("control", control, NONE);
    wait_cycles(1);
  endtask

  task automatic send_byte(input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      uart_rx = frame[i];
      wait_cycles(SIM_BIT_CYCLES);
    end
    wait_cycles(SIM_BIT_CYCLES);
    push_expected(key_command(data));
  endtask

  task automatic set_panel(input logic is_switch, input logic [1:0] idx, input logic level);
    if (is_switch)
      usr_sw[idx] = level;
    else
      usr_btn[idx] = level;
  endtask

  task automatic press_panel(input logic is_switch, input logic [1:0] idx, input int hold);
    set_panel(is_switch, idx, 1'b1);
    wait_cycles(hold);
    push_expected(panel_command(is_switch, idx));
    set_panel(is_switch, idx, 1'b0);
    wait_cycles(RELEASE_CYCLES);
  endtask

  // Each WAIT cycle shows a new head, then the queue must stay empty.
  task automatic drain_and_check();
    int waited;
    waited = 0;
    state  = WAIT;
    while ((model_queue.size() > 0) && (waited < DRAIN_LIMIT)) begin
      @(negedge clk);
      waited++;
      if (control != NONE)
        check_equal("control", control, model_queue.pop_front());
    end
    if (model_queue.size() > 0)
      report_failure("Queued commands never reached control during WAIT.");
    repeat (QUIET_CYCLES) begin
      @(negedge clk);
      check_equal("control", control, NONE);
    end
    @(posedge clk);
    #5;
    state = IDLE;
  endtask

  // ####################
  // Tests.
  initial begin : run_tests
    int          offset;
    int          last;
    int          downs;
    logic [1:0]  idx;
    logic [2:0]  sel;
    game_state_t rest;
    lfsr    = 16'd60;
    reset_n = 1'b0;
    uart_rx = 1'b1;
    usr_btn = '0;
    usr_sw  = '0;
    state   = IDLE;

    // Quiet after reset, in a random non-WAIT state and then in WAIT.
    apply_reset();
    rest  = rand_bits(1) ? ACT : IDLE;
    state = rest;
    repeat (20) begin
      @(negedge clk);
      check_equal("control", control, NONE);
    end
    wait_cycles(1);
    state = WAIT;
    repeat (20) begin
      @(negedge clk);
      check_equal("control", control, NONE);
    end
    wait_cycles(1);
    state = IDLE;
    press_panel(1'b0, 2'(rand_bits(2)), PRESS_CYCLES);
    drain_and_check();

    // UART keys, each followed by a random byte.
    apply_reset();
    offset = rand_bits(4);
    for (int j = 0; j < 17; j++) begin
      send_byte(KEY_CHARS[(offset + j) % 17]);
      send_byte(rand_bits(8));
      if ((j % 4 == 3) || (j == 16))
        drain_and_check();
    end

    // Button bounces and presses.
    apply_reset();
    for (int t = 0; t < BTN_TRIALS; t++) begin
      idx = 2'(rand_bits(2));
      set_panel(1'b0, idx, 1'b1);
      wait_cycles(1 + rand_bits(2));
      set_panel(1'b0, idx, 1'b0);
      wait_cycles(RELEASE_CYCLES);
      press_panel(1'b0, idx, PRESS_CYCLES + rand_bits(3));
    end
    drain_and_check();

    // A held switch gives one command until it is pressed again.
    apply_reset();
    for (int t = 0; t < SW_TRIALS; t++) begin
      idx = 2'(rand_bits(2));
      set_panel(1'b1, idx, 1'b1);
      wait_cycles(LONG_HOLD);
      push_expected(panel_command(1'b1, idx));
      drain_and_check();
      set_panel(1'b1, idx, 1'b0);
      wait_cycles(RELEASE_CYCLES);
      press_panel(1'b1, idx, PRESS_CYCLES);
      drain_and_check();
    end

    // Overflow, the last two presses are lost.
    apply_reset();
    for (int n = 0; n < QUEUE_DEPTH + 2; n++) begin
      sel = 3'(rand_bits(3));
      press_panel(sel[2], sel[1:0], PRESS_CYCLES);
    end
    drain_and_check();

    // Gravity in WAIT, then nothing in IDLE.
    apply_reset();
    state = WAIT;
    last  = 0;
    downs = 0;
    for (int i = 0; i < 3 * SIM_GRAVITY_TICK + 20; i++) begin
      @(negedge clk);
      if (control != NONE) begin
        check_equal("control", control, DOWN);
        if ((i - last < SIM_GRAVITY_TICK - 1) || (i - last > SIM_GRAVITY_TICK + 1))
          report_failure("Gravity DOWN appeared at the wrong interval.");
        last = i;
        downs++;
      end
    end
    check_equal("gravity DOWN count", downs, 3);
    wait_cycles(1);
    state = IDLE;
    repeat (3 * SIM_GRAVITY_TICK) begin
      @(negedge clk);
      check_equal("control", control, NONE);
    end

    $display("Testbench passed");
    $finish;
  end

endmodule
